// ==== Bender.yml ====
package:
  name: rv32i_decoder

sources:
  - rv_pkg.sv
  - instr_classifier.sv
  - imm_gen.sv
  - branch_unit.sv
  - decode_stage.sv
  - decoder_top.sv
  - target: simulation
    files:
      - decoder_props.sv
      - decoder_tb.sv

// ==== branch_unit.sv ====
module branch_unit
  import rv_pkg::*;
(
  input  word_t pc,
  input  ctrl_e ctrl,
  input  word_t imm,
  input  word_t reg_rs1,
  input  word_t reg_rs2,
  output word_t next_pc
);

  word_t seq_pc;
  word_t rel_pc;
  word_t reg_pc;
  logic  equal;
  logic  less_s;
  logic  less_u;
  logic  taken;

  assign seq_pc = pc + 32'd4;
  assign rel_pc = pc + imm;
  // jalr target drops bit 0
  assign reg_pc = (reg_rs1 + imm) & ~32'd1;

  assign equal  = reg_rs1 == reg_rs2;
  assign less_s = $signed(reg_rs1) < $signed(reg_rs2);
  assign less_u = reg_rs1 < reg_rs2;

  always_comb begin
    case (ctrl)
      ctrl_beq:  taken = equal;
      ctrl_bne:  taken = !equal;
      ctrl_blt:  taken = less_s;
      ctrl_bge:  taken = !less_s;
      ctrl_bltu: taken = less_u;
      ctrl_bgeu: taken = !less_u;
      ctrl_jal:  taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl == ctrl_jalr) begin
      next_pc = reg_pc;
    end else if (taken) begin
      next_pc = rel_pc;
    end else begin
      next_pc = seq_pc;
    end
  end

endmodule

// ==== decode_stage.sv ====
module decode_stage
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  word_t       pc,
  input  class_t      cls,
  input  word_t       imm,
  input  word_t       reg_rs1,
  input  word_t       reg_rs2,
  input  reg_addr_t   shamt,
  input  word_t       next_pc,
  output decode_out_t out,
  output logic        out_valid,
  input  logic        out_ready
);

  logic        accept;
  logic        is_jump;
  word_t       op_a;
  word_t       op_b;
  decode_out_t bundle;

  // single slot, refilled in the cycle it drains
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  assign is_jump = cls.ctrl == ctrl_jal || cls.ctrl == ctrl_jalr;

  // first operand
  always_comb begin
    if (cls.zero_a) begin
      op_a = '0;
    end else if (cls.use_pc) begin
      op_a = pc;
    end else begin
      op_a = reg_rs1;
    end
  end

  // second operand, link step for jumps
  always_comb begin
    if (is_jump) begin
      op_b = 32'd4;
    end else if (cls.use_shamt) begin
      op_b = {27'b0, shamt};
    end else if (cls.use_imm) begin
      op_b = imm;
    end else begin
      op_b = reg_rs2;
    end
  end

  always_comb begin
    bundle.op_a        = op_a;
    bundle.op_b        = op_b;
    bundle.rd          = cls.rd;
    bundle.alu_op      = cls.alu_op;
    bundle.mem_op      = cls.mem_op;
    bundle.mem_addr    = reg_rs1 + imm;
    bundle.next_pc     = next_pc;
    bundle.valid_instr = cls.valid_instr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload only moves on a transfer in
  always_ff @(posedge clk) begin
    if (accept) begin
      out <= bundle;
    end
  end

endmodule

// ==== decoder_props.sv ====
module decoder_props
  import rv_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        in_valid,
  input logic        out_valid,
  input logic        out_ready,
  input decode_out_t out
);

  // count of failed assertions
  int fails = 0;

  // slot is empty once reset has been seen
  assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high after reset");
      fails++;
    end

  // back-pressure freezes the bundle
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out))
    else begin
      $error("out changed while stalled");
      fails++;
    end

  // an empty stage takes whatever is offered
  assert property (@(posedge clk) disable iff (reset) !out_valid && in_valid |=> out_valid)
    else begin
      $error("empty stage did not take an offered item");
      fails++;
    end

endmodule

bind decode_stage decoder_props u_props (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out       (out)
);

// ==== decoder_tb.sv ====
module decoder_tb
  import rv_pkg::*;
();

  // about two cycles per decoded item plus reset and the stall
  localparam int test_cycles = 6 + 2 * (19 + 8 + 23 + 5) + 13;
  localparam int cycle_limit = 2 * test_cycles;

  localparam logic [2:0] chk_rs1 = 3'b001;
  localparam logic [2:0] chk_rs2 = 3'b010;
  localparam logic [2:0] chk_ops = 3'b100;

  logic        clk;
  logic        reset;
  fetch_t      in;
  logic        in_valid;
  logic        in_ready;
  reg_addr_t   rs1_addr;
  reg_addr_t   rs2_addr;
  word_t       reg_rs1;
  word_t       reg_rs2;
  decode_out_t out;
  logic        out_valid;
  logic        out_ready;
  int          errors;
  int          passed;
  int          failed;
  int          cycles;

  decoder_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_alu(string name, alu_op_e got, alu_op_e exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mem(string name, mem_op_e got, mem_op_e exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(string name, int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      failed++;
    end
  endtask

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t sext(word_t v, int bits);
    return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  function automatic decode_out_t bundle(word_t a, word_t b, reg_addr_t rd, alu_op_e alu,
                                         mem_op_e mem, word_t addr, word_t npc, logic ok);
    return '{a, b, rd, alu, mem, addr, npc, ok};
  endfunction

  // one transfer in and the bundle one cycle later
  task automatic decode_check(word_t instr, word_t pc, reg_addr_t rs1, reg_addr_t rs2,
                              word_t v1, word_t v2, logic [2:0] chk, decode_out_t exp);
    @(negedge clk);
    in = {instr, pc};
    in_valid = 1'b1;
    reg_rs1 = v1;
    reg_rs2 = v2;
    while (!in_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
    check_bit("out_valid", out_valid, 1'b1);
    if (chk[0]) check_reg("rs1_addr", rs1_addr, rs1);
    if (chk[1]) check_reg("rs2_addr", rs2_addr, rs2);
    if (chk[2]) begin
      check_word("op_a", out.op_a, exp.op_a);
      check_word("op_b", out.op_b, exp.op_b);
    end
    check_reg("rd", out.rd, exp.rd);
    check_alu("alu_op", out.alu_op, exp.alu_op);
    check_mem("mem_op", out.mem_op, exp.mem_op);
    if (exp.mem_op != mem_none) check_word("mem_addr", out.mem_addr, exp.mem_addr);
    check_word("next_pc", out.next_pc, exp.next_pc);
    check_bit("valid_instr", out.valid_instr, exp.valid_instr);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    finish_test("reset", e0);
  endtask

  task automatic test_alu();
    alu_op_e     r_ops [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    logic [2:0]  r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    alu_op_e     i_ops [9] = '{alu_add, alu_slt, alu_sltu, alu_xor, alu_or,
                               alu_and, alu_sll, alu_srl, alu_sra};
    logic [2:0]  i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
    logic [11:0] imm;
    logic [6:0]  f7;
    word_t       v1;
    word_t       v2;
    word_t       pc;
    word_t       b;
    reg_addr_t   rd;
    int          e0;
    int          k;
    e0 = errors;
    for (k = 0; k < 10; k++) begin
      v1 = $urandom;
      v2 = $urandom;
      pc = $urandom & ~32'd3;
      rd = reg_addr_t'(k + 1);
      f7 = (k == 1 || k == 7) ? 7'h20 : 7'h00;
      decode_check(enc_r(f7, rd + 5'd10, rd + 5'd20, r_f3[k], rd, 7'b0110011), pc,
                   rd + 5'd20, rd + 5'd10, v1, v2, chk_rs1 | chk_rs2 | chk_ops,
                   bundle(v1, v2, rd, r_ops[k], mem_none, 32'd0, pc + 4, 1'b1));
    end
    for (k = 0; k < 9; k++) begin
      v1 = $urandom;
      pc = $urandom & ~32'd3;
      rd = reg_addr_t'(k + 4);
      imm = 12'($urandom);
      // shifts carry funct7 in the upper immediate bits
      if (k >= 6) imm[11:5] = (k == 8) ? 7'h20 : 7'h00;
      b = (k < 6) ? sext(imm, 12) : {27'b0, imm[4:0]};
      decode_check(enc_i(imm, rd + 5'd7, i_f3[k], rd, 7'b0010011), pc, rd + 5'd7, 5'd0,
                   v1, 32'd0, chk_rs1 | chk_ops,
                   bundle(v1, b, rd, i_ops[k], mem_none, 32'd0, pc + 4, 1'b1));
    end
    finish_test("alu", e0);
  endtask

  task automatic test_mem();
    mem_op_e     m_ops [8] = '{mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
                               mem_sb, mem_sh, mem_sw};
    logic [2:0]  m_f3 [8] = '{0, 1, 2, 4, 5, 0, 1, 2};
    logic [11:0] imm;
    word_t       v1;
    word_t       v2;
    word_t       pc;
    word_t       addr;
    reg_addr_t   rd;
    int          e0;
    int          k;
    e0 = errors;
    for (k = 0; k < 8; k++) begin
      v1 = $urandom;
      v2 = $urandom;
      pc = $urandom & ~32'd3;
      imm = 12'($urandom);
      rd = reg_addr_t'(k + 2);
      addr = v1 + sext(imm, 12);
      if (k < 5) begin
        decode_check(enc_i(imm, rd + 5'd9, m_f3[k], rd, 7'b0000011), pc, rd + 5'd9, 5'd0,
                     v1, v2, chk_rs1 | chk_ops,
                     bundle(v1, sext(imm, 12), rd, alu_none, m_ops[k], addr, pc + 4, 1'b1));
      end else begin
        decode_check(enc_s(imm, rd + 5'd17, rd + 5'd9, m_f3[k]), pc, rd + 5'd9, rd + 5'd17,
                     v1, v2, chk_rs1 | chk_rs2 | chk_ops,
                     bundle(v1, v2, 5'd0, alu_none, m_ops[k], addr, pc + 4, 1'b1));
      end
    end
    finish_test("load_store", e0);
  endtask

  task automatic test_ctrl();
    logic [2:0]  b_f3 [6] = '{0, 1, 4, 5, 6, 7};
    logic [7:0]  tk;
    logic [12:0] off;
    logic [20:0] joff;
    logic [19:0] uimm;
    logic [11:0] imm;
    word_t       a;
    word_t       b;
    word_t       v1;
    word_t       v2;
    word_t       pc;
    word_t       npc;
    int          e0;
    int          k;
    e0 = errors;
    for (k = 0; k < 18; k++) begin
      // negative against positive so signed and unsigned order disagree
      a = $urandom | 32'h8000_0000;
      b = $urandom & 32'h7fff_ffff;
      v1 = (k % 3 == 2) ? b : a;
      v2 = (k % 3 == 1) ? b : a;
      off = 13'($urandom) & ~13'd1;
      pc = $urandom & ~32'd3;
      tk = {!(v1 < v2), v1 < v2, !($signed(v1) < $signed(v2)), $signed(v1) < $signed(v2),
            2'b00, v1 != v2, v1 == v2};
      npc = tk[b_f3[k / 3]] ? pc + sext(off, 13) : pc + 4;
      decode_check(enc_b(off, reg_addr_t'(k + 12), reg_addr_t'(k + 1), b_f3[k / 3]), pc,
                   reg_addr_t'(k + 1), reg_addr_t'(k + 12), v1, v2,
                   chk_rs1 | chk_rs2 | chk_ops,
                   bundle(v1, v2, 5'd0, alu_none, mem_none, 32'd0, npc, 1'b1));
    end
    pc = $urandom & ~32'd3;
    joff = 21'($urandom) & ~21'd1;
    decode_check(enc_j(joff, 5'd1), pc, 5'd0, 5'd0, 32'd0, 32'd0, chk_ops,
                 bundle(pc, 32'd4, 5'd1, alu_add, mem_none, 32'd0, pc + sext(joff, 21), 1'b1));
    for (k = 0; k < 2; k++) begin
      // odd register plus even offset leaves bit 0 to clear
      v1 = $urandom | 32'd1;
      imm = 12'($urandom) & ~12'd1;
      npc = (v1 + sext(imm, 12)) & ~32'd1;
      decode_check(enc_i(imm, 5'd6, 3'b000, 5'd5, 7'b1100111), pc, 5'd6, 5'd0, v1, 32'd0,
                   chk_rs1 | chk_ops,
                   bundle(pc, 32'd4, 5'd5, alu_add, mem_none, 32'd0, npc, 1'b1));
    end
    uimm = 20'($urandom);
    decode_check(enc_u(uimm, 5'd7, 7'b0110111), pc, 5'd0, 5'd0, $urandom, 32'd0, chk_ops,
                 bundle(32'd0, {uimm, 12'b0}, 5'd7, alu_add, mem_none, 32'd0, pc + 4, 1'b1));
    decode_check(enc_u(uimm, 5'd8, 7'b0010111), pc, 5'd0, 5'd0, $urandom, 32'd0, chk_ops,
                 bundle(pc, {uimm, 12'b0}, 5'd8, alu_add, mem_none, 32'd0, pc + 4, 1'b1));
    finish_test("control", e0);
  endtask

  task automatic test_invalid();
    word_t bad [5];
    word_t pc;
    int    e0;
    int    k;
    e0 = errors;
    // addi with low bits 10 as in a compressed quadrant
    bad[0] = 32'h00a5_0512;
    bad[1] = enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011);
    bad[2] = enc_i(12'h300, 5'd1, 3'b001, 5'd2, 7'b1110011);
    bad[3] = 32'h0000_0073;
    bad[4] = 32'h1234_567f;
    for (k = 0; k < 5; k++) begin
      pc = $urandom & ~32'd3;
      decode_check(bad[k], pc, 5'd0, 5'd0, $urandom, $urandom, 3'b000,
                   bundle(32'd0, 32'd0, 5'd0, alu_none, mem_none, 32'd0, pc + 4, 1'b0));
    end
    finish_test("invalid", e0);
  endtask

  task automatic test_stream();
    decode_out_t exp;
    int          e0;
    int          k;
    e0 = errors;
    // let the previous item drain before stalling
    @(negedge clk);
    out_ready = 1'b0;
    exp = bundle(32'd5, 32'h7ff, 5'd2, alu_add, mem_none, 32'd0, 32'h104, 1'b1);
    decode_check(enc_i(12'h7ff, 5'd1, 3'b000, 5'd2, 7'b0010011), 32'h100, 5'd1, 5'd0,
                 32'd5, 32'd0, chk_rs1 | chk_ops, exp);
    // first stream item waits until the slot drains
    in = {enc_u(20'h1, 5'd3, 7'b0110111), 32'h200};
    in_valid = 1'b1;
    for (k = 0; k < 3; k++) begin
      @(negedge clk);
      check_bit("in_ready", in_ready, 1'b0);
      check_bit("out_valid", out_valid, 1'b1);
      check_word("op_a", out.op_a, exp.op_a);
      check_word("op_b", out.op_b, exp.op_b);
      check_word("next_pc", out.next_pc, exp.next_pc);
      check_reg("rd", out.rd, exp.rd);
    end
    out_ready = 1'b1;
    for (k = 0; k < 4; k++) begin
      in = {enc_u(20'(k + 1), reg_addr_t'(k + 3), 7'b0110111), 32'h200 + 32'(4 * k)};
      in_valid = 1'b1;
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b1);
      check_word("op_b", out.op_b, {20'(k + 1), 12'b0});
      check_word("next_pc", out.next_pc, 32'h204 + 32'(4 * k));
    end
    in_valid = 1'b0;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    finish_test("stream", e0);
  endtask

  initial begin
    errors = 0;
    passed = 0;
    failed = 0;
    cycles = 0;
    void'($urandom(73753));
    reset = 1'b1;
    in = '0;
    in_valid = 1'b0;
    reg_rs1 = '0;
    reg_rs2 = '0;
    out_ready = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_alu();
    test_mem();
    test_ctrl();
    test_invalid();
    test_stream();
    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0 && errors == 0 && UUT.u_stage.u_props.fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== decoder_top.sv ====
module decoder_top
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  fetch_t      in,
  input  logic        in_valid,
  output logic        in_ready,
  output reg_addr_t   rs1_addr,
  output reg_addr_t   rs2_addr,
  input  word_t       reg_rs1,
  input  word_t       reg_rs2,
  output decode_out_t out,
  output logic        out_valid,
  input  logic        out_ready
);

  class_t cls;
  word_t  imm;
  word_t  next_pc;

  instr_classifier u_classifier (
    .instr    (in.instr),
    .cls      (cls),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  imm_gen u_imm_gen (
    .instr   (in.instr),
    .imm_fmt (cls.imm_fmt),
    .imm     (imm)
  );

  branch_unit u_branch (
    .pc      (in.pc),
    .ctrl    (cls.ctrl),
    .imm     (imm),
    .reg_rs1 (reg_rs1),
    .reg_rs2 (reg_rs2),
    .next_pc (next_pc)
  );

  // rs2 field doubles as the shift amount
  decode_stage u_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .pc        (in.pc),
    .cls       (cls),
    .imm       (imm),
    .reg_rs1   (reg_rs1),
    .reg_rs2   (reg_rs2),
    .shamt     (rs2_addr),
    .next_pc   (next_pc),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== imm_gen.sv ====
module imm_gen
  import rv_pkg::*;
(
  input  word_t    instr,
  input  imm_fmt_e imm_fmt,
  output word_t    imm
);

  word_t i_imm;
  word_t s_imm;
  word_t b_imm;
  word_t u_imm;
  word_t j_imm;

  // all formats sign-extend from bit 31
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign u_imm = {instr[31:12], 12'b0};

  // branch and jump offsets are in halfwords
  assign b_imm = {
    {20{instr[31]}},
    instr[7],
    instr[30:25],
    instr[11:8],
    1'b0
  };
  assign j_imm = {
    {12{instr[31]}},
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  always_comb begin
    case (imm_fmt)
      imm_i:   imm = i_imm;
      imm_s:   imm = s_imm;
      imm_b:   imm = b_imm;
      imm_u:   imm = u_imm;
      imm_j:   imm = j_imm;
      default: imm = '0;
    endcase
  end

endmodule

// ==== instr_classifier.sv ====
module instr_classifier
  import rv_pkg::*;
(
  input  word_t     instr,
  output class_t    cls,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr
);

  // major opcodes in bits 6:2
  localparam logic [4:0] op_load   = 5'b00000;
  localparam logic [4:0] op_imm    = 5'b00100;
  localparam logic [4:0] op_auipc  = 5'b00101;
  localparam logic [4:0] op_store  = 5'b01000;
  localparam logic [4:0] op_reg    = 5'b01100;
  localparam logic [4:0] op_lui    = 5'b01101;
  localparam logic [4:0] op_branch = 5'b11000;
  localparam logic [4:0] op_jalr   = 5'b11001;
  localparam logic [4:0] op_jal    = 5'b11011;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       uncompressed;
  logic       f7_zero;
  logic       f7_alt;
  alu_op_e    base_alu;

  assign opcode       = instr[6:2];
  assign funct3       = instr[14:12];
  assign funct7       = instr[31:25];
  assign uncompressed = instr[1:0] == 2'b11;
  assign f7_zero      = funct7 == 7'b0000000;
  assign f7_alt       = funct7 == 7'b0100000;

  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  base_alu = alu_add;
      3'b001:  base_alu = alu_sll;
      3'b010:  base_alu = alu_slt;
      3'b011:  base_alu = alu_sltu;
      3'b100:  base_alu = alu_xor;
      3'b101:  base_alu = f7_alt ? alu_sra : alu_srl;
      3'b110:  base_alu = alu_or;
      default: base_alu = alu_and;
    endcase
  end

  always_comb begin
    cls = '0;
    if (uncompressed) begin
      case (opcode)
        op_lui, op_auipc: begin
          cls.alu_op      = alu_add;
          cls.imm_fmt     = imm_u;
          cls.rd          = instr[11:7];
          cls.use_imm     = 1'b1;
          cls.zero_a      = opcode == op_lui;
          cls.use_pc      = opcode == op_auipc;
          cls.valid_instr = 1'b1;
        end
        op_jal, op_jalr: begin
          cls.alu_op      = alu_add;
          cls.ctrl        = (opcode == op_jal) ? ctrl_jal : ctrl_jalr;
          cls.imm_fmt     = (opcode == op_jal) ? imm_j : imm_i;
          cls.rd          = instr[11:7];
          cls.use_pc      = 1'b1;
          cls.valid_instr = opcode == op_jal || funct3 == 3'b000;
        end
        op_branch: begin
          case (funct3)
            3'b000:  cls.ctrl = ctrl_beq;
            3'b001:  cls.ctrl = ctrl_bne;
            3'b100:  cls.ctrl = ctrl_blt;
            3'b101:  cls.ctrl = ctrl_bge;
            3'b110:  cls.ctrl = ctrl_bltu;
            3'b111:  cls.ctrl = ctrl_bgeu;
            default: cls.ctrl = ctrl_none;
          endcase
          cls.imm_fmt     = imm_b;
          cls.valid_instr = cls.ctrl != ctrl_none;
        end
        op_load: begin
          case (funct3)
            3'b000:  cls.mem_op = mem_lb;
            3'b001:  cls.mem_op = mem_lh;
            3'b010:  cls.mem_op = mem_lw;
            3'b100:  cls.mem_op = mem_lbu;
            3'b101:  cls.mem_op = mem_lhu;
            default: cls.mem_op = mem_none;
          endcase
          cls.imm_fmt     = imm_i;
          cls.rd          = instr[11:7];
          cls.use_imm     = 1'b1;
          cls.valid_instr = cls.mem_op != mem_none;
        end
        op_store: begin
          case (funct3)
            3'b000:  cls.mem_op = mem_sb;
            3'b001:  cls.mem_op = mem_sh;
            3'b010:  cls.mem_op = mem_sw;
            default: cls.mem_op = mem_none;
          endcase
          // op_b stays on rs2 for the store data
          cls.imm_fmt     = imm_s;
          cls.valid_instr = cls.mem_op != mem_none;
        end
        op_imm: begin
          cls.alu_op      = base_alu;
          cls.imm_fmt     = imm_i;
          cls.rd          = instr[11:7];
          cls.use_shamt   = funct3 == 3'b001 || funct3 == 3'b101;
          cls.use_imm     = !cls.use_shamt;
          cls.valid_instr = (funct3 == 3'b001) ? f7_zero :
                            (funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;
        end
        op_reg: begin
          cls.alu_op      = (funct3 == 3'b000 && f7_alt) ? alu_sub : base_alu;
          cls.rd          = instr[11:7];
          cls.valid_instr = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end
        default: cls = '0;
      endcase
    end
    // anything unmatched leaves no trace
    if (!cls.valid_instr) begin
      cls = '0;
    end
  end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [3:0] {
    alu_none,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb,
    mem_lh,
    mem_lw,
    mem_lbu,
    mem_lhu,
    mem_sb,
    mem_sh,
    mem_sw
  } mem_op_e;

  typedef enum logic [3:0] {
    ctrl_none,
    ctrl_jal,
    ctrl_jalr,
    ctrl_beq,
    ctrl_bne,
    ctrl_blt,
    ctrl_bge,
    ctrl_bltu,
    ctrl_bgeu
  } ctrl_e;

  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_e;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  // classifier result, all zero for an unknown word
  typedef struct packed {
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    ctrl_e     ctrl;
    imm_fmt_e  imm_fmt;
    reg_addr_t rd;
    logic      use_imm;
    logic      use_shamt;
    logic      use_pc;
    logic      zero_a;
    logic      valid_instr;
  } class_t;

  typedef struct packed {
    word_t     op_a;
    word_t     op_b;
    reg_addr_t rd;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    word_t     mem_addr;
    word_t     next_pc;
    logic      valid_instr;
  } decode_out_t;

endpackage

// ==== verilog.f ====
rv_pkg.sv
instr_classifier.sv
imm_gen.sv
branch_unit.sv
decode_stage.sv
decoder_top.sv
decoder_props.sv
decoder_tb.sv
